// ==== include/csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// CSR numbers
`define CSR_CRMD        14'h0000
`define CSR_PRMD        14'h0001
`define CSR_ECFG        14'h0004
`define CSR_ESTAT       14'h0005
`define CSR_ERA         14'h0006
`define CSR_BADV        14'h0007
`define CSR_EENTRY      14'h000c
`define CSR_SAVE0       14'h0030
`define CSR_SAVE1       14'h0031
`define CSR_SAVE2       14'h0032
`define CSR_SAVE3       14'h0033
`define CSR_TID         14'h0040
`define CSR_TCFG        14'h0041
`define CSR_TVAL        14'h0042
`define CSR_TICLR       14'h0044
// Stable counter halves, mapped into the CSR space of this unit
`define CSR_TIMER_L     14'h0060
`define CSR_TIMER_H     14'h0061

// CRMD and PRMD fields
`define PLV             1:0
`define IE              2
`define DA              3
`define PG              4
`define DATF            6:5
`define DATM            8:7
`define PPLV            1:0
`define PIE             2

// ESTAT fields
`define IS_SOFT         1:0
`define IS_HARD         9:2
`define IS_TI           11
`define ECODE           21:16
`define ESUBCODE        30:22

// EENTRY, ECFG, timer fields
`define EENTRY_VA       31:6
`define LIE             12:0
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2
`define TICLR_CLR       0

`define CRMD_RESET      32'h0000_0008

`define CMD_QUEUE_DEPTH 4
`define RESP_CREDITS    2

`endif

// ==== verilog/csr_pkg.sv ====
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;

    // Command kinds carried through the queue
    typedef enum logic [2:0] {
        CSR_OP_RD,
        CSR_OP_WR,
        CSR_OP_XCHG,
        CSR_OP_ERTN,
        CSR_OP_EXCP
    } csr_op_t;

endpackage

// ==== verilog/excp_pkg.sv ====
package excp_pkg;

    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [7:0]  intrpt_t;
    // Status and enable bits shared by ESTAT and ECFG
    typedef logic [12:0] irq_vec_t;

endpackage

// ==== verilog/csr_cmd_queue.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_cmd_queue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  csr_pkg::csr_op_t     cmd_op,
    input  csr_pkg::csr_addr_t   cmd_addr,
    input  csr_pkg::csr_data_t   cmd_wdata,
    input  csr_pkg::csr_data_t   cmd_mask,
    input  excp_pkg::ecode_t     cmd_ecode,
    input  excp_pkg::esubcode_t  cmd_esubcode,
    input  csr_pkg::csr_data_t   cmd_era,
    input  csr_pkg::csr_data_t   cmd_badv,
    input  logic                 cmd_use_badv,
    output logic                 cmd_credit,
    output logic                 q_nonempty,
    output csr_pkg::csr_op_t     q_op,
    output csr_pkg::csr_addr_t   q_addr,
    output csr_pkg::csr_data_t   q_wdata,
    output csr_pkg::csr_data_t   q_mask,
    output excp_pkg::ecode_t     q_ecode,
    output excp_pkg::esubcode_t  q_esubcode,
    output csr_pkg::csr_data_t   q_era,
    output csr_pkg::csr_data_t   q_badv,
    output logic                 q_use_badv,
    input  logic                 out_ready
);
    import csr_pkg::*;
    import excp_pkg::*;

    localparam int DEPTH = `CMD_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    csr_op_t    mem_op       [DEPTH];
    csr_addr_t  mem_addr     [DEPTH];
    csr_data_t  mem_wdata    [DEPTH];
    csr_data_t  mem_mask     [DEPTH];
    ecode_t     mem_ecode    [DEPTH];
    esubcode_t  mem_esubcode [DEPTH];
    csr_data_t  mem_era      [DEPTH];
    csr_data_t  mem_badv     [DEPTH];
    logic       mem_use_badv [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             empty;
    logic             pop;

    assign empty = (count == '0);
    // Empty queue hands the incoming command straight to the head
    assign q_nonempty = !empty || cmd_valid;
    assign pop = q_nonempty && out_ready;

    always_comb
    begin
        if (empty)
        begin
            q_op       = cmd_op;
            q_addr     = cmd_addr;
            q_wdata    = cmd_wdata;
            q_mask     = cmd_mask;
            q_ecode    = cmd_ecode;
            q_esubcode = cmd_esubcode;
            q_era      = cmd_era;
            q_badv     = cmd_badv;
            q_use_badv = cmd_use_badv;
        end
        else
        begin
            q_op       = mem_op[rd_ptr];
            q_addr     = mem_addr[rd_ptr];
            q_wdata    = mem_wdata[rd_ptr];
            q_mask     = mem_mask[rd_ptr];
            q_ecode    = mem_ecode[rd_ptr];
            q_esubcode = mem_esubcode[rd_ptr];
            q_era      = mem_era[rd_ptr];
            q_badv     = mem_badv[rd_ptr];
            q_use_badv = mem_use_badv[rd_ptr];
        end
    end

    // Also written on bypass, where both pointers move together
    always_ff @(posedge clk)
    begin
        if (cmd_valid)
        begin
            mem_op[wr_ptr]       <= cmd_op;
            mem_addr[wr_ptr]     <= cmd_addr;
            mem_wdata[wr_ptr]    <= cmd_wdata;
            mem_mask[wr_ptr]     <= cmd_mask;
            mem_ecode[wr_ptr]    <= cmd_ecode;
            mem_esubcode[wr_ptr] <= cmd_esubcode;
            mem_era[wr_ptr]      <= cmd_era;
            mem_badv[wr_ptr]     <= cmd_badv;
            mem_use_badv[wr_ptr] <= cmd_use_badv;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            if (cmd_valid)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({cmd_valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per popped entry
            cmd_credit <= pop;
        end
    end

endmodule

// ==== verilog/csr_file.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 q_nonempty,
    input  logic                 out_ready,
    input  csr_pkg::csr_op_t     q_op,
    input  csr_pkg::csr_addr_t   q_addr,
    input  csr_pkg::csr_data_t   q_wdata,
    input  csr_pkg::csr_data_t   q_mask,
    input  excp_pkg::ecode_t     q_ecode,
    input  excp_pkg::esubcode_t  q_esubcode,
    input  csr_pkg::csr_data_t   q_era,
    input  csr_pkg::csr_data_t   q_badv,
    input  logic                 q_use_badv,
    input  excp_pkg::intrpt_t    intrpt,
    input  logic                 timer_fire,
    input  csr_pkg::csr_data_t   tcfg_rd,
    input  csr_pkg::csr_data_t   tval_rd,
    input  csr_pkg::csr_data_t   timer_lo,
    input  csr_pkg::csr_data_t   timer_hi,
    output logic                 tcfg_we,
    output csr_pkg::csr_data_t   tcfg_wdata,
    output csr_pkg::csr_data_t   rdata,
    output logic                 redirect,
    output csr_pkg::csr_data_t   redirect_pc,
    output logic                 have_intrpt,
    output csr_pkg::plv_t        crmd_plv
);
    import csr_pkg::*;
    import excp_pkg::*;

    csr_data_t crmd;
    csr_data_t prmd;
    csr_data_t estat;
    csr_data_t era;
    csr_data_t eentry;
    csr_data_t save [4];
    csr_data_t ecfg;
    csr_data_t tid;
    csr_data_t badv;

    logic      pop;
    logic      wr_en;
    logic      excp;
    logic      ertn;
    csr_data_t old_val;
    csr_data_t wmask;
    csr_data_t wval;
    irq_vec_t  irq_pend;

    assign pop   = q_nonempty && out_ready;
    assign wr_en = pop && (q_op == CSR_OP_WR || q_op == CSR_OP_XCHG);
    assign excp  = pop && (q_op == CSR_OP_EXCP);
    assign ertn  = pop && (q_op == CSR_OP_ERTN);

    always_comb
    begin
        case (q_addr)
            `CSR_CRMD:    old_val = crmd;
            `CSR_PRMD:    old_val = prmd;
            `CSR_ESTAT:   old_val = estat;
            `CSR_ERA:     old_val = era;
            `CSR_EENTRY:  old_val = eentry;
            `CSR_SAVE0:   old_val = save[0];
            `CSR_SAVE1:   old_val = save[1];
            `CSR_SAVE2:   old_val = save[2];
            `CSR_SAVE3:   old_val = save[3];
            `CSR_ECFG:    old_val = ecfg;
            `CSR_TID:     old_val = tid;
            `CSR_TCFG:    old_val = tcfg_rd;
            `CSR_TVAL:    old_val = tval_rd;
            `CSR_BADV:    old_val = badv;
            `CSR_TIMER_L: old_val = timer_lo;
            `CSR_TIMER_H: old_val = timer_hi;
            default:      old_val = '0;
        endcase
    end

    // Full write behaves as an exchange with every mask bit set
    assign wmask = (q_op == CSR_OP_WR) ? '1 : q_mask;
    assign wval  = (old_val & ~wmask) | (q_wdata & wmask);

    assign rdata       = old_val;
    assign redirect    = (q_op == CSR_OP_EXCP) || (q_op == CSR_OP_ERTN);
    assign redirect_pc = (q_op == CSR_OP_EXCP) ? eentry : era;

    assign tcfg_we    = wr_en && (q_addr == `CSR_TCFG);
    assign tcfg_wdata = wval;

    assign irq_pend    = ecfg[`LIE] & {1'b0, estat[`IS_TI], 1'b0, estat[`IS_HARD], estat[`IS_SOFT]};
    assign have_intrpt = crmd[`IE] && (|irq_pend);
    assign crmd_plv    = crmd[`PLV];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            crmd   <= `CRMD_RESET;
            prmd   <= '0;
            era    <= '0;
            eentry <= '0;
            save   <= '{default: '0};
            ecfg   <= '0;
            tid    <= '0;
            badv   <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                case (q_addr)
                    `CSR_CRMD:
                    begin
                        crmd[`PLV]  <= wval[`PLV];
                        crmd[`IE]   <= wval[`IE];
                        crmd[`DA]   <= wval[`DA];
                        crmd[`PG]   <= wval[`PG];
                        crmd[`DATF] <= wval[`DATF];
                        crmd[`DATM] <= wval[`DATM];
                    end
                    `CSR_PRMD:
                    begin
                        prmd[`PPLV] <= wval[`PPLV];
                        prmd[`PIE]  <= wval[`PIE];
                    end
                    `CSR_ERA:    era <= wval;
                    `CSR_EENTRY: eentry[`EENTRY_VA] <= wval[`EENTRY_VA];
                    `CSR_SAVE0:  save[0] <= wval;
                    `CSR_SAVE1:  save[1] <= wval;
                    `CSR_SAVE2:  save[2] <= wval;
                    `CSR_SAVE3:  save[3] <= wval;
                    // LIE bit 10 is reserved
                    `CSR_ECFG:   ecfg[`LIE] <= wval[`LIE] & 13'h1bff;
                    `CSR_TID:    tid <= wval;
                    `CSR_BADV:   badv <= wval;
                    default:     ;
                endcase
            end
            if (excp)
            begin
                prmd[`PPLV] <= crmd[`PLV];
                prmd[`PIE]  <= crmd[`IE];
                crmd[`PLV]  <= 2'b00;
                crmd[`IE]   <= 1'b0;
                era         <= q_era;
                if (q_use_badv)
                begin
                    badv <= q_badv;
                end
            end
            if (ertn)
            begin
                crmd[`PLV] <= prmd[`PPLV];
                crmd[`IE]  <= prmd[`PIE];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            estat <= '0;
        end
        else
        begin
            // Hardware lines are sampled every cycle
            estat[`IS_HARD] <= intrpt;
            if (wr_en && q_addr == `CSR_ESTAT)
            begin
                estat[`IS_SOFT] <= wval[`IS_SOFT];
            end
            if (excp)
            begin
                estat[`ECODE]    <= q_ecode;
                estat[`ESUBCODE] <= q_esubcode;
            end
            // Expiry wins over a TICLR clear in the same cycle
            if (timer_fire)
            begin
                estat[`IS_TI] <= 1'b1;
            end
            else if (wr_en && q_addr == `CSR_TICLR && wval[`TICLR_CLR])
            begin
                estat[`IS_TI] <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/csr_timer.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_timer (
    input  logic                clk,
    input  logic                rst,
    input  logic                tcfg_we,
    input  csr_pkg::csr_data_t  tcfg_wdata,
    output csr_pkg::csr_data_t  tcfg_rd,
    output csr_pkg::csr_data_t  tval_rd,
    output csr_pkg::csr_data_t  timer_lo,
    output csr_pkg::csr_data_t  timer_hi,
    output logic                timer_fire
);
    import csr_pkg::*;

    csr_data_t   tcfg;
    csr_data_t   tval;
    logic        timer_en;
    logic [63:0] stable_cnt;

    assign timer_fire = timer_en && (tval == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tcfg     <= '0;
            tval     <= '0;
            timer_en <= 1'b0;
        end
        else if (tcfg_we)
        begin
            tcfg     <= tcfg_wdata;
            tval     <= {tcfg_wdata[`TCFG_INITVAL], 2'b00};
            timer_en <= tcfg_wdata[`TCFG_EN];
        end
        else if (timer_en)
        begin
            if (tval != '0)
            begin
                tval <= tval - 1'b1;
            end
            else if (tcfg[`TCFG_PERIODIC])
            begin
                tval <= {tcfg[`TCFG_INITVAL], 2'b00};
            end
            else
            begin
                // One-shot mode stops at zero
                timer_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stable_cnt <= '0;
        end
        else
        begin
            stable_cnt <= stable_cnt + 64'd1;
        end
    end

    assign tcfg_rd  = tcfg;
    assign tval_rd  = tval;
    assign timer_lo = stable_cnt[31:0];
    assign timer_hi = stable_cnt[63:32];

endmodule

// ==== verilog/csr_resp.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_resp (
    input  logic                clk,
    input  logic                rst,
    input  logic                pop,
    input  csr_pkg::csr_data_t  rdata,
    input  logic                redirect,
    input  csr_pkg::csr_data_t  redirect_pc,
    input  logic                resp_credit,
    output logic                out_ready,
    output logic                resp_valid,
    output csr_pkg::csr_data_t  resp_rdata,
    output logic                resp_redirect,
    output csr_pkg::csr_data_t  resp_pc
);
    localparam int CRED_W = $clog2(`RESP_CREDITS + 1);

    logic [CRED_W-1:0] credits;

    // A pop is allowed only while a downstream slot is known free
    assign out_ready = (credits != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            credits    <= CRED_W'(`RESP_CREDITS);
            resp_valid <= 1'b0;
        end
        else
        begin
            case ({pop, resp_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            resp_valid <= pop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            resp_rdata    <= rdata;
            resp_redirect <= redirect;
            resp_pc       <= redirect_pc;
        end
    end

endmodule

// ==== verilog/csr_unit_top.sv ====
`timescale 1ns/100ps

module csr_unit_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  csr_pkg::csr_op_t     cmd_op,
    input  csr_pkg::csr_addr_t   cmd_addr,
    input  csr_pkg::csr_data_t   cmd_wdata,
    input  csr_pkg::csr_data_t   cmd_mask,
    input  excp_pkg::ecode_t     cmd_ecode,
    input  excp_pkg::esubcode_t  cmd_esubcode,
    input  csr_pkg::csr_data_t   cmd_era,
    input  csr_pkg::csr_data_t   cmd_badv,
    input  logic                 cmd_use_badv,
    output logic                 cmd_credit,
    output logic                 resp_valid,
    output csr_pkg::csr_data_t   resp_rdata,
    output logic                 resp_redirect,
    output csr_pkg::csr_data_t   resp_pc,
    input  logic                 resp_credit,
    input  excp_pkg::intrpt_t    intrpt,
    output logic                 have_intrpt,
    output csr_pkg::plv_t        crmd_plv
);
    import csr_pkg::*;
    import excp_pkg::*;

    logic      q_nonempty;
    csr_op_t   q_op;
    csr_addr_t q_addr;
    csr_data_t q_wdata;
    csr_data_t q_mask;
    ecode_t    q_ecode;
    esubcode_t q_esubcode;
    csr_data_t q_era;
    csr_data_t q_badv;
    logic      q_use_badv;
    logic      out_ready;
    logic      pop;

    logic      tcfg_we;
    csr_data_t tcfg_wdata;
    csr_data_t tcfg_rd;
    csr_data_t tval_rd;
    csr_data_t timer_lo;
    csr_data_t timer_hi;
    logic      timer_fire;

    csr_data_t rdata;
    logic      redirect;
    csr_data_t redirect_pc;

    assign pop = q_nonempty && out_ready;

    csr_cmd_queue i_csr_cmd_queue (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .cmd_mask     (cmd_mask),
        .cmd_ecode    (cmd_ecode),
        .cmd_esubcode (cmd_esubcode),
        .cmd_era      (cmd_era),
        .cmd_badv     (cmd_badv),
        .cmd_use_badv (cmd_use_badv),
        .cmd_credit   (cmd_credit),
        .q_nonempty   (q_nonempty),
        .q_op         (q_op),
        .q_addr       (q_addr),
        .q_wdata      (q_wdata),
        .q_mask       (q_mask),
        .q_ecode      (q_ecode),
        .q_esubcode   (q_esubcode),
        .q_era        (q_era),
        .q_badv       (q_badv),
        .q_use_badv   (q_use_badv),
        .out_ready    (out_ready)
    );

    csr_file i_csr_file (
        .clk         (clk),
        .rst         (rst),
        .q_nonempty  (q_nonempty),
        .out_ready   (out_ready),
        .q_op        (q_op),
        .q_addr      (q_addr),
        .q_wdata     (q_wdata),
        .q_mask      (q_mask),
        .q_ecode     (q_ecode),
        .q_esubcode  (q_esubcode),
        .q_era       (q_era),
        .q_badv      (q_badv),
        .q_use_badv  (q_use_badv),
        .intrpt      (intrpt),
        .timer_fire  (timer_fire),
        .tcfg_rd     (tcfg_rd),
        .tval_rd     (tval_rd),
        .timer_lo    (timer_lo),
        .timer_hi    (timer_hi),
        .tcfg_we     (tcfg_we),
        .tcfg_wdata  (tcfg_wdata),
        .rdata       (rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .have_intrpt (have_intrpt),
        .crmd_plv    (crmd_plv)
    );

    csr_timer i_csr_timer (
        .clk        (clk),
        .rst        (rst),
        .tcfg_we    (tcfg_we),
        .tcfg_wdata (tcfg_wdata),
        .tcfg_rd    (tcfg_rd),
        .tval_rd    (tval_rd),
        .timer_lo   (timer_lo),
        .timer_hi   (timer_hi),
        .timer_fire (timer_fire)
    );

    csr_resp i_csr_resp (
        .clk           (clk),
        .rst           (rst),
        .pop           (pop),
        .rdata         (rdata),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .resp_credit   (resp_credit),
        .out_ready     (out_ready),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .resp_redirect (resp_redirect),
        .resp_pc       (resp_pc)
    );

endmodule

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_unit_tb;
    import csr_pkg::*;
    import excp_pkg::*;

    logic clk;
    logic rst;
    logic cmd_valid;
    csr_op_t cmd_op;
    csr_addr_t cmd_addr;
    csr_data_t cmd_wdata;
    csr_data_t cmd_mask;
    ecode_t cmd_ecode;
    esubcode_t cmd_esubcode;
    csr_data_t cmd_era;
    csr_data_t cmd_badv;
    logic cmd_use_badv;
    logic cmd_credit;
    logic resp_valid;
    csr_data_t resp_rdata;
    logic resp_redirect;
    csr_data_t resp_pc;
    logic resp_credit;
    intrpt_t intrpt;
    logic have_intrpt;
    plv_t crmd_plv;

    int errors;
    int timeouts;
    int cmd_cred;
    int sent_total;
    int credit_pulses;
    int resp_total;
    int returned;
    logic auto_credit;
    csr_data_t rdata_q[$];
    logic redir_q[$];
    csr_data_t pc_q[$];
    csr_data_t eentry_val;

    csr_unit_top i_csr_unit_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Sender credits and response capture
    always @(posedge clk)
    begin
        if (rst)
        begin
            cmd_cred <= `CMD_QUEUE_DEPTH;
        end
        else
        begin
            cmd_cred <= cmd_cred - int'(cmd_valid) + int'(cmd_credit);
            if (cmd_credit)
                credit_pulses <= credit_pulses + 1;
            if (resp_valid)
            begin
                rdata_q.push_back(resp_rdata);
                redir_q.push_back(resp_redirect);
                pc_q.push_back(resp_pc);
                resp_total <= resp_total + 1;
            end
        end
    end

    // Hand one response credit back per response when enabled
    always @(negedge clk)
    begin
        if (auto_credit && returned < resp_total)
        begin
            resp_credit <= 1'b1;
            returned <= returned + 1;
        end
        else
        begin
            resp_credit <= 1'b0;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic issue(input csr_op_t op, input csr_addr_t addr, input csr_data_t wdata,
                         input csr_data_t mask, input ecode_t ec, input esubcode_t esc,
                         input csr_data_t era, input csr_data_t badv, input logic use_badv);
        int n;
        n = 0;
        @(negedge clk);
        while (cmd_cred == 0 && n < 200)
        begin
            n++;
            @(negedge clk);
        end
        if (cmd_cred == 0)
        begin
            timeouts++;
            $display("Timed out waiting for a command credit");
        end
        else
        begin
            cmd_valid = 1'b1;
            cmd_op = op;
            cmd_addr = addr;
            cmd_wdata = wdata;
            cmd_mask = mask;
            cmd_ecode = ec;
            cmd_esubcode = esc;
            cmd_era = era;
            cmd_badv = badv;
            cmd_use_badv = use_badv;
            sent_total++;
            @(negedge clk);
            cmd_valid = 1'b0;
        end
    endtask

    task automatic wait_resp(output csr_data_t data, output logic redir, output csr_data_t pc);
        int n;
        n = 0;
        data = '0;
        redir = 1'b0;
        pc = '0;
        while (rdata_q.size() == 0 && n < 200)
        begin
            n++;
            @(negedge clk);
        end
        if (rdata_q.size() == 0)
        begin
            timeouts++;
            $display("Timed out waiting for a response");
        end
        else
        begin
            data = rdata_q.pop_front();
            redir = redir_q.pop_front();
            pc = pc_q.pop_front();
        end
    endtask

    task automatic send_cmd(input csr_op_t op, input csr_addr_t addr, input csr_data_t wdata,
                            input csr_data_t mask, output csr_data_t data);
        logic redir;
        csr_data_t pc;
        issue(op, addr, wdata, mask, '0, '0, '0, '0, 1'b0);
        wait_resp(data, redir, pc);
        check_value("resp_redirect", redir, 1'b0);
    endtask

    task automatic read_expect(input string name, input csr_addr_t addr, input csr_data_t exp);
        csr_data_t d;
        send_cmd(CSR_OP_RD, addr, '0, '0, d);
        check_value(name, d, exp);
    endtask

    task automatic wait_intrpt(input logic level, input int limit);
        int n;
        n = 0;
        while (have_intrpt !== level && n < limit)
        begin
            n++;
            @(negedge clk);
        end
        if (have_intrpt !== level)
        begin
            timeouts++;
            $display("Timed out waiting for have_intrpt to become %0b", level);
        end
    endtask

    task automatic test_reset_state();
        check_value("resp_valid", resp_valid, 1'b0);
        check_value("cmd_credit", cmd_credit, 1'b0);
        read_expect("crmd", `CSR_CRMD, `CRMD_RESET);
        read_expect("prmd", `CSR_PRMD, 32'h0);
        read_expect("estat", `CSR_ESTAT, 32'h0);
        read_expect("era", `CSR_ERA, 32'h0);
        read_expect("eentry", `CSR_EENTRY, 32'h0);
        read_expect("save0", `CSR_SAVE0, 32'h0);
        read_expect("tval", `CSR_TVAL, 32'h0);
        check_value("have_intrpt", have_intrpt, 1'b0);
    endtask

    task automatic test_read_write();
        csr_addr_t addrs[5];
        csr_data_t vals[5];
        csr_data_t d;
        csr_data_t m;
        csr_data_t w;
        addrs = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID};
        foreach (addrs[i])
        begin
            vals[i] = $urandom;
            send_cmd(CSR_OP_WR, addrs[i], vals[i], '0, d);
            check_value("resp_rdata", d, 32'h0);
            read_expect("rd after wr", addrs[i], vals[i]);
        end
        m = $urandom;
        w = $urandom;
        send_cmd(CSR_OP_XCHG, `CSR_SAVE0, w, m, d);
        check_value("xchg old", d, vals[0]);
        read_expect("xchg merged", `CSR_SAVE0, (vals[0] & ~m) | (w & m));
        // Only the VA bits of EENTRY are writable
        eentry_val = $urandom;
        send_cmd(CSR_OP_WR, `CSR_EENTRY, eentry_val, '0, d);
        eentry_val = eentry_val & 32'hffff_ffc0;
        read_expect("eentry", `CSR_EENTRY, eentry_val);
        w = $urandom;
        send_cmd(CSR_OP_WR, `CSR_ESTAT, w, '0, d);
        read_expect("estat soft", `CSR_ESTAT, w & 32'h3);
        send_cmd(CSR_OP_WR, `CSR_ESTAT, 32'h0, '0, d);
    endtask

    task automatic excp_round(input logic use_badv, input plv_t plv, input logic ie,
                              inout csr_data_t badv_exp);
        csr_data_t d;
        csr_data_t pc;
        logic redir;
        ecode_t ec;
        esubcode_t esc;
        csr_data_t era;
        csr_data_t badv;
        csr_data_t crmd_val;
        ec = 6'($urandom);
        esc = 9'($urandom);
        era = $urandom;
        badv = $urandom;
        crmd_val = `CRMD_RESET | {29'h0, ie, plv};
        send_cmd(CSR_OP_WR, `CSR_CRMD, crmd_val, '0, d);
        issue(CSR_OP_EXCP, '0, '0, '0, ec, esc, era, badv, use_badv);
        wait_resp(d, redir, pc);
        check_value("resp_redirect", redir, 1'b1);
        check_value("resp_pc", pc, eentry_val);
        read_expect("prmd", `CSR_PRMD, {29'h0, ie, plv});
        read_expect("crmd", `CSR_CRMD, crmd_val & 32'hffff_fff8);
        check_value("crmd_plv", crmd_plv, 2'b00);
        read_expect("era", `CSR_ERA, era);
        send_cmd(CSR_OP_RD, `CSR_ESTAT, '0, '0, d);
        check_value("ecode", d[21:16], ec);
        check_value("esubcode", d[30:22], esc);
        if (use_badv)
            badv_exp = badv;
        read_expect("badv", `CSR_BADV, badv_exp);
        issue(CSR_OP_ERTN, '0, '0, '0, '0, '0, '0, '0, 1'b0);
        wait_resp(d, redir, pc);
        check_value("resp_redirect", redir, 1'b1);
        check_value("resp_pc", pc, era);
        read_expect("crmd", `CSR_CRMD, crmd_val);
        check_value("crmd_plv", crmd_plv, plv);
    endtask

    task automatic test_exception();
        csr_data_t badv_exp;
        csr_data_t d;
        badv_exp = '0;
        excp_round(1'b0, 2'b11, 1'b1, badv_exp);
        excp_round(1'b1, 2'b01, 1'b0, badv_exp);
        send_cmd(CSR_OP_WR, `CSR_CRMD, `CRMD_RESET, '0, d);
    endtask

    task automatic test_interrupt();
        csr_data_t d;
        send_cmd(CSR_OP_WR, `CSR_ECFG, 32'h4, '0, d);
        send_cmd(CSR_OP_WR, `CSR_CRMD, 32'hc, '0, d);
        intrpt = 8'h01;
        wait_intrpt(1'b1, 20);
        intrpt = 8'h00;
        wait_intrpt(1'b0, 20);
        intrpt = 8'h01;
        wait_intrpt(1'b1, 20);
        send_cmd(CSR_OP_WR, `CSR_CRMD, 32'h8, '0, d);
        wait_intrpt(1'b0, 20);
        intrpt = 8'h00;
    endtask

    task automatic test_timer();
        csr_data_t d;
        csr_data_t t0;
        csr_data_t t1;
        send_cmd(CSR_OP_WR, `CSR_ECFG, 32'h800, '0, d);
        send_cmd(CSR_OP_WR, `CSR_CRMD, 32'hc, '0, d);
        send_cmd(CSR_OP_WR, `CSR_TCFG, 32'h21, '0, d);
        send_cmd(CSR_OP_RD, `CSR_TVAL, '0, '0, t0);
        send_cmd(CSR_OP_RD, `CSR_TVAL, '0, '0, t1);
        check_value("tval loaded", (t0 != 0) && (t0 <= 32'h20), 1'b1);
        check_value("tval non-increasing", t1 <= t0, 1'b1);
        wait_intrpt(1'b1, 200);
        send_cmd(CSR_OP_WR, `CSR_TICLR, 32'h1, '0, d);
        check_value("have_intrpt after ticlr", have_intrpt, 1'b0);
        repeat (60) @(negedge clk);
        check_value("have_intrpt one-shot", have_intrpt, 1'b0);
        // Periodic mode fires again after a clear
        send_cmd(CSR_OP_WR, `CSR_TCFG, 32'h23, '0, d);
        wait_intrpt(1'b1, 200);
        send_cmd(CSR_OP_WR, `CSR_TICLR, 32'h1, '0, d);
        check_value("have_intrpt periodic ticlr", have_intrpt, 1'b0);
        wait_intrpt(1'b1, 200);
        send_cmd(CSR_OP_WR, `CSR_TCFG, 32'h0, '0, d);
        send_cmd(CSR_OP_WR, `CSR_TICLR, 32'h1, '0, d);
        wait_intrpt(1'b0, 20);
        send_cmd(CSR_OP_RD, `CSR_TIMER_L, '0, '0, t0);
        send_cmd(CSR_OP_RD, `CSR_TIMER_L, '0, '0, t1);
        check_value("timer_l increases", t1 > t0, 1'b1);
        send_cmd(CSR_OP_WR, `CSR_ECFG, 32'h0, '0, d);
        send_cmd(CSR_OP_WR, `CSR_CRMD, 32'h8, '0, d);
    endtask

    task automatic test_flow_control();
        csr_data_t vals[$];
        csr_data_t prev;
        csr_data_t d;
        csr_data_t pc;
        logic redir;
        int n;
        int base;
        send_cmd(CSR_OP_RD, `CSR_SAVE1, '0, '0, prev);
        repeat (4) @(negedge clk);
        auto_credit = 1'b0;
        base = resp_total;
        n = 0;
        while (cmd_cred > 0 && n < 12)
        begin
            vals.push_back($urandom);
            issue(CSR_OP_WR, `CSR_SAVE1, vals[n], '0, '0, '0, '0, '0, 1'b0);
            n++;
            repeat (2) @(negedge clk);
        end
        repeat (20) @(negedge clk);
        check_value("responses held", resp_total - base, `RESP_CREDITS);
        check_value("sender credits", cmd_cred, 0);
        auto_credit = 1'b1;
        foreach (vals[i])
        begin
            wait_resp(d, redir, pc);
            check_value("flow resp_rdata", d, prev);
            prev = vals[i];
        end
        read_expect("save1 final", `CSR_SAVE1, prev);
        repeat (4) @(negedge clk);
        check_value("cmd_credit pulses", credit_pulses, sent_total);
    endtask

    initial
    begin
        void'($urandom(45));
        errors = 0;
        timeouts = 0;
        sent_total = 0;
        credit_pulses = 0;
        resp_total = 0;
        returned = 0;
        auto_credit = 1'b1;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = CSR_OP_RD;
        cmd_addr = '0;
        cmd_wdata = '0;
        cmd_mask = '0;
        cmd_ecode = '0;
        cmd_esubcode = '0;
        cmd_era = '0;
        cmd_badv = '0;
        cmd_use_badv = 1'b0;
        resp_credit = 1'b0;
        intrpt = '0;
        eentry_val = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_read_write();
        test_exception();
        test_interrupt();
        test_timer();
        test_flow_control();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
+incdir+include
verilog/csr_pkg.sv
verilog/excp_pkg.sv
verilog/csr_cmd_queue.sv
verilog/csr_file.sv
verilog/csr_timer.sv
verilog/csr_resp.sv
verilog/csr_unit_top.sv
verification/csr_unit_tb.sv

// ==== Makefile ====
TOP = csr_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f csr_unit.f --top-module $(TOP)

sim:
	verilator --binary --timing -f csr_unit.f --top-module $(TOP) -o csr_unit_sim
	./obj_dir/csr_unit_sim | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
